/* rv32_isa_pkg.sv */
package rv32_isa_pkg;

   typedef logic [4:0] reg_addr_t;

   // same 32 bits seen as register-register or immediate format
   typedef union packed {
      struct packed {
         logic [6:0] funct7;
         reg_addr_t  rs2;
         reg_addr_t  rs1;
         logic [2:0] funct3;
         reg_addr_t  rd;
         logic [6:0] opcode;
      } r_view;
      struct packed {
         logic [11:0] funct12;
         reg_addr_t   rs1;
         logic [2:0]  funct3;
         reg_addr_t   rd;
         logic [6:0]  opcode;
      } i_view;
   } rv32_inst_u;

   localparam logic [6:0] op_load     = 7'b0000011;
   localparam logic [6:0] op_store    = 7'b0100011;
   localparam logic [6:0] op_branch   = 7'b1100011;
   localparam logic [6:0] op_jal      = 7'b1101111;
   localparam logic [6:0] op_jalr     = 7'b1100111;
   localparam logic [6:0] op_misc_mem = 7'b0001111;
   localparam logic [6:0] op_op_imm   = 7'b0010011;
   localparam logic [6:0] op_op       = 7'b0110011;
   localparam logic [6:0] op_system   = 7'b1110011;
   localparam logic [6:0] op_auipc    = 7'b0010111;
   localparam logic [6:0] op_lui      = 7'b0110111;

   localparam logic [2:0] funct3_beq  = 3'b000;
   localparam logic [2:0] funct3_bne  = 3'b001;
   localparam logic [2:0] funct3_blt  = 3'b100;
   localparam logic [2:0] funct3_bge  = 3'b101;
   localparam logic [2:0] funct3_bltu = 3'b110;
   localparam logic [2:0] funct3_bgeu = 3'b111;

   localparam logic [2:0] funct3_add_sub = 3'b000;
   localparam logic [2:0] funct3_sll     = 3'b001;
   localparam logic [2:0] funct3_slt     = 3'b010;
   localparam logic [2:0] funct3_sltu    = 3'b011;
   localparam logic [2:0] funct3_xor     = 3'b100;
   localparam logic [2:0] funct3_sra_srl = 3'b101;
   localparam logic [2:0] funct3_or      = 3'b110;
   localparam logic [2:0] funct3_and     = 3'b111;

   localparam logic [2:0] funct3_fence   = 3'b000;
   localparam logic [2:0] funct3_fence_i = 3'b001;
   localparam logic [2:0] funct3_priv    = 3'b000;

   localparam logic [6:0]  funct7_alt     = 7'b0100000; // sub, sra
   localparam logic [11:0] funct12_ecall  = 12'h000;
   localparam logic [11:0] funct12_ebreak = 12'h001;

endpackage

/* pipe_ctrl_pkg.sv */
package pipe_ctrl_pkg;
   import rv32_isa_pkg::*;

   typedef enum logic [3:0] {
      alu_add  = 4'd0,
      alu_sll  = 4'd1,
      alu_xor  = 4'd4,
      alu_srl  = 4'd5,
      alu_or   = 4'd6,
      alu_and  = 4'd7,
      alu_seq  = 4'd8,
      alu_sne  = 4'd9,
      alu_sub  = 4'd10,
      alu_sra  = 4'd11,
      alu_slt  = 4'd12,
      alu_sge  = 4'd13,
      alu_sltu = 4'd14,
      alu_sgeu = 4'd15
   } alu_op_t;

   typedef enum logic [1:0] {imm_i = 2'd0, imm_s = 2'd1, imm_u = 2'd2} imm_type_t;

   typedef enum logic [1:0] {src_a_rs1 = 2'd0, src_a_pc = 2'd1, src_a_zero = 2'd2} src_a_sel_t;

   typedef enum logic [1:0] {src_b_rs2 = 2'd0, src_b_imm = 2'd1, src_b_four = 2'd2} src_b_sel_t;

   typedef enum logic {wb_src_alu = 1'b0, wb_src_mem = 1'b1} wb_src_sel_t;

   typedef enum logic [2:0] {
      pc_plus_four     = 3'd0,
      pc_branch_target = 3'd1,
      pc_jal_target    = 3'd2,
      pc_jalr_target   = 3'd3,
      pc_replay        = 3'd4,
      pc_handler       = 3'd5
   } pc_src_sel_t;

   // machine cause numbers
   typedef enum logic [3:0] {
      ecode_inst_addr_misaligned  = 4'd0,
      ecode_inst_access_fault     = 4'd1,
      ecode_illegal_inst          = 4'd2,
      ecode_breakpoint            = 4'd3,
      ecode_load_addr_misaligned  = 4'd4,
      ecode_load_access_fault     = 4'd5,
      ecode_store_addr_misaligned = 4'd6,
      ecode_store_access_fault    = 4'd7,
      ecode_ecall_from_m          = 4'd11
   } ecode_t;

   typedef struct packed {
      imm_type_t  imm_type;
      src_a_sel_t src_a_sel;
      src_b_sel_t src_b_sel;
   } dx_ctrl_t;

   // raw decode, before kill gating
   typedef struct packed {
      alu_op_t     alu_op;
      logic        uses_rs1;
      logic        uses_rs2;
      logic        branch_taken;
      logic        jal;
      logic        jalr;
      logic        fence_i;
      logic        dmem_en;
      logic        dmem_wen;
      logic        wr_reg;
      wb_src_sel_t wb_src_sel;
      logic        illegal;
      logic        ecall;
      logic        ebreak;
   } decode_t;

   typedef struct packed {
      logic       en;
      logic       wen;
      logic [2:0] size;
      logic [2:0] mem_type;
   } dmem_req_t;

   typedef struct packed {
      logic        wr_reg;
      reg_addr_t   reg_to_wr;
      wb_src_sel_t wb_src_sel;
   } wb_ctrl_t;

   typedef struct packed {
      logic stall_if;
      logic kill_if;
      logic stall_dx;
      logic kill_dx;
      logic stall_wb;
      logic kill_wb;
   } pipe_status_t;

endpackage

/* inst_decoder.sv */
`timescale 1ns/1ps

module inst_decoder
   import rv32_isa_pkg::*;
   import pipe_ctrl_pkg::*;
(
   input  rv32_inst_u inst_dx,
   input  logic       cmp_true,
   output decode_t    dec,
   output dx_ctrl_t   dx_ctrl,
   output logic [2:0] dmem_size,
   output logic [2:0] dmem_type
);

   logic [6:0]  opcode;
   logic [2:0]  funct3;
   logic [6:0]  funct7;
   logic [11:0] funct12;
   reg_addr_t   rs1;
   reg_addr_t   rd;
   logic        is_shift;
   logic        bad_funct7;
   alu_op_t     alu_op_arith;

   assign opcode  = inst_dx.r_view.opcode;
   assign funct3  = inst_dx.r_view.funct3;
   assign funct7  = inst_dx.r_view.funct7;
   assign funct12 = inst_dx.i_view.funct12;
   assign rs1     = inst_dx.i_view.rs1;
   assign rd      = inst_dx.i_view.rd;

   assign dmem_size = {1'b0, funct3[1:0]};
   assign dmem_type = funct3; // bit 2 marks unsigned loads

   assign is_shift = (funct3 == funct3_sll) || (funct3 == funct3_sra_srl);
   // alternate funct7 only on sub/sra, also catches shamt[5]
   assign bad_funct7 = (funct7 != 7'd0) && !((funct7 == funct7_alt) &&
                       ((funct3 == funct3_add_sub) || (funct3 == funct3_sra_srl)));

   always_comb begin
      case (funct3)
         funct3_add_sub: alu_op_arith = (opcode == op_op && funct7[5]) ? alu_sub : alu_add;
         funct3_sll:     alu_op_arith = alu_sll;
         funct3_slt:     alu_op_arith = alu_slt;
         funct3_sltu:    alu_op_arith = alu_sltu;
         funct3_xor:     alu_op_arith = alu_xor;
         funct3_sra_srl: alu_op_arith = funct7[5] ? alu_sra : alu_srl;
         funct3_or:      alu_op_arith = alu_or;
         funct3_and:     alu_op_arith = alu_and;
         default:        alu_op_arith = alu_add;
      endcase
   end

   always_comb begin
      dec = '0;
      dec.alu_op = alu_add;
      dec.uses_rs1 = 1'b1;
      dec.wb_src_sel = wb_src_alu;
      dx_ctrl.imm_type = imm_i;
      dx_ctrl.src_a_sel = src_a_rs1;
      dx_ctrl.src_b_sel = src_b_imm;
      case (opcode)
         op_load: begin
            dec.dmem_en = 1'b1;
            dec.wr_reg = 1'b1;
            dec.wb_src_sel = wb_src_mem;
            dec.illegal = (funct3[1:0] == 2'b11) || (funct3 == 3'b110);
         end
         op_store: begin
            dec.uses_rs2 = 1'b1;
            dec.dmem_en = 1'b1;
            dec.dmem_wen = 1'b1;
            dx_ctrl.imm_type = imm_s;
            dec.illegal = funct3[2] || (funct3[1:0] == 2'b11);
         end
         op_branch: begin
            dec.uses_rs2 = 1'b1;
            dec.branch_taken = cmp_true;
            dx_ctrl.src_b_sel = src_b_rs2;
            case (funct3)
               funct3_beq:  dec.alu_op = alu_seq;
               funct3_bne:  dec.alu_op = alu_sne;
               funct3_blt:  dec.alu_op = alu_slt;
               funct3_bge:  dec.alu_op = alu_sge;
               funct3_bltu: dec.alu_op = alu_sltu;
               funct3_bgeu: dec.alu_op = alu_sgeu;
               default:     dec.illegal = 1'b1;
            endcase
         end
         op_jal, op_jalr: begin
            dec.jal = (opcode == op_jal);
            dec.jalr = (opcode == op_jalr);
            dec.uses_rs1 = (opcode == op_jalr);
            dec.wr_reg = 1'b1;
            dx_ctrl.src_a_sel = src_a_pc; // link value is pc + 4
            dx_ctrl.src_b_sel = src_b_four;
            dec.illegal = (opcode == op_jalr) && (funct3 != 3'b000);
         end
         op_misc_mem: begin
            if (funct3 == funct3_fence)
               dec.illegal = (funct12[11:8] != 4'd0) || (rs1 != '0) || (rd != '0);
            else if (funct3 == funct3_fence_i && funct12 == '0 && rs1 == '0 && rd == '0)
               dec.fence_i = 1'b1;
            else
               dec.illegal = 1'b1;
         end
         op_op_imm: begin
            dec.alu_op = alu_op_arith;
            dec.wr_reg = 1'b1;
            dec.illegal = is_shift && bad_funct7;
         end
         op_op: begin
            dec.uses_rs2 = 1'b1;
            dec.alu_op = alu_op_arith;
            dec.wr_reg = 1'b1;
            dx_ctrl.src_b_sel = src_b_rs2;
            dec.illegal = bad_funct7;
         end
         op_system: begin
            // no csr support, only ecall and ebreak
            dec.ecall = (funct3 == funct3_priv) && (rs1 == '0) && (rd == '0) &&
                        (funct12 == funct12_ecall);
            dec.ebreak = (funct3 == funct3_priv) && (rs1 == '0) && (rd == '0) &&
                         (funct12 == funct12_ebreak);
            dec.illegal = !(dec.ecall || dec.ebreak);
         end
         op_auipc, op_lui: begin
            dec.uses_rs1 = 1'b0;
            dec.wr_reg = 1'b1;
            dx_ctrl.imm_type = imm_u;
            dx_ctrl.src_a_sel = (opcode == op_lui) ? src_a_zero : src_a_pc;
         end
         default: dec.illegal = 1'b1;
      endcase
   end

endmodule

/* hazard_unit.sv */
`timescale 1ns/1ps

module hazard_unit
   import rv32_isa_pkg::*;
   import pipe_ctrl_pkg::*;
(
   input  rv32_inst_u inst_dx,
   input  logic       uses_rs1,
   input  logic       uses_rs2,
   input  wb_ctrl_t   wb,
   input  logic       load_in_wb,
   output logic       bypass_rs1,
   output logic       bypass_rs2,
   output logic       load_use
);

   reg_addr_t rs1;
   reg_addr_t rs2;
   logic      raw_rs1;
   logic      raw_rs2;

   assign rs1 = inst_dx.r_view.rs1;
   assign rs2 = inst_dx.r_view.rs2;

   // x0 never creates a dependency
   assign raw_rs1 = wb.wr_reg && uses_rs1 && (rs1 != '0) && (rs1 == wb.reg_to_wr);
   assign raw_rs2 = wb.wr_reg && uses_rs2 && (rs2 != '0) && (rs2 == wb.reg_to_wr);

   // load data arrives too late to forward
   assign bypass_rs1 = raw_rs1 && !load_in_wb;
   assign bypass_rs2 = raw_rs2 && !load_in_wb;
   assign load_use   = load_in_wb && (raw_rs1 || raw_rs2);

endmodule

/* pipe_ctrl.sv */
`timescale 1ns/1ps

module pipe_ctrl
   import rv32_isa_pkg::*;
   import pipe_ctrl_pkg::*;
(
   input  logic         clk,
   input  logic         reset,
   input  decode_t      dec,
   input  reg_addr_t    rd_dx,
   input  logic         load_use,
   input  logic         imem_wait,
   input  logic         imem_badmem_e,
   input  logic         dmem_wait,
   input  logic         dmem_badmem_e,
   input  logic         misaligned_addr_p,
   input  logic         misaligned_fetch,
   input  logic [2:0]   dmem_size,
   input  logic [2:0]   dmem_type,
   output pc_src_sel_t  pc_src_sel,
   output dmem_req_t    dmem_req,
   output wb_ctrl_t     wb,
   output logic         load_in_wb,
   output pipe_status_t status,
   output logic         exception_wb,
   output ecode_t       exception_code_wb,
   output logic         retire_wb
);

   logic        replay_if;
   logic        had_ex_dx, prev_killed_dx;
   logic        prev_killed_wb, had_ex_wb, wr_reg_unkilled_wb, store_in_wb, dmem_en_wb;
   wb_src_sel_t wb_src_sel_wb;
   reg_addr_t   reg_to_wr_wb;
   ecode_t      prev_ex_code_wb, ex_code_dx;
   logic        stall_if, kill_if, stall_dx, kill_dx, stall_wb, kill_wb;
   logic        ex_if, ex_dx, ex_wb, killed_dx, misaligned_addr, redirect;
   logic        dmem_en_dx, dmem_wen_dx, wr_reg_dx;

   always_ff @(posedge clk) begin
      if (reset)
         replay_if <= 1'b1; // first fetch after reset is refetched
      else
         replay_if <= (redirect && imem_wait) || (dec.fence_i && store_in_wb);
   end

   assign ex_if    = imem_badmem_e && !imem_wait && !redirect && !replay_if;
   assign stall_if = stall_dx || (imem_wait && !redirect && !ex_wb);
   assign kill_if  = stall_if || ex_if || ex_dx || ex_wb || redirect || replay_if;

   always_ff @(posedge clk) begin
      if (reset) begin
         had_ex_dx <= 1'b0;
         prev_killed_dx <= 1'b1;
      end else if (!stall_dx) begin
         had_ex_dx <= ex_if;
         prev_killed_dx <= kill_if;
      end
   end

   assign misaligned_addr = misaligned_addr_p && dec.dmem_en;
   assign ex_dx = had_ex_dx || misaligned_addr || misaligned_fetch ||
                  dec.illegal || dec.ebreak || dec.ecall;
   // exceptions win over internal hazards
   assign stall_dx = stall_wb ||
                     ((load_use || (dec.fence_i && store_in_wb)) && !(ex_dx || ex_wb));
   assign kill_dx   = stall_dx || ex_dx || ex_wb;
   assign killed_dx = prev_killed_dx || kill_dx;

   always_comb begin
      ex_code_dx = ecode_ecall_from_m;
      if (had_ex_dx)
         ex_code_dx = ecode_inst_access_fault;
      else if (misaligned_addr)
         ex_code_dx = dec.dmem_wen ? ecode_store_addr_misaligned : ecode_load_addr_misaligned;
      else if (misaligned_fetch)
         ex_code_dx = ecode_inst_addr_misaligned;
      else if (dec.illegal)
         ex_code_dx = ecode_illegal_inst;
      else if (dec.ebreak)
         ex_code_dx = ecode_breakpoint;
   end

   assign dmem_en_dx  = dec.dmem_en && !kill_dx;
   assign dmem_wen_dx = dec.dmem_wen && !kill_dx;
   assign wr_reg_dx   = dec.wr_reg && !kill_dx;
   assign redirect    = (dec.branch_taken || dec.jal || dec.jalr) && !kill_dx;

   always_comb begin
      if (ex_wb)
         pc_src_sel = pc_handler;
      else if (replay_if || (stall_if && !imem_wait))
         pc_src_sel = pc_replay;
      else if (dec.branch_taken)
         pc_src_sel = pc_branch_target;
      else if (dec.jal)
         pc_src_sel = pc_jal_target;
      else if (dec.jalr)
         pc_src_sel = pc_jalr_target;
      else
         pc_src_sel = pc_plus_four;
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         prev_killed_wb <= 1'b1;
         had_ex_wb <= 1'b0;
         wr_reg_unkilled_wb <= 1'b0;
         store_in_wb <= 1'b0;
         dmem_en_wb <= 1'b0;
      end else if (!stall_wb) begin
         prev_killed_wb <= killed_dx;
         had_ex_wb <= ex_dx && !ex_wb; // trap in WB flushes the DX one
         wr_reg_unkilled_wb <= wr_reg_dx;
         store_in_wb <= dmem_wen_dx;
         dmem_en_wb <= dmem_en_dx;
      end
   end

   always_ff @(posedge clk) begin
      if (!stall_wb) begin
         wb_src_sel_wb <= dec.wb_src_sel;
         reg_to_wr_wb <= rd_dx;
         prev_ex_code_wb <= ex_code_dx;
      end
   end

   assign ex_wb    = had_ex_wb || (dmem_badmem_e && dmem_en_wb);
   assign stall_wb = dmem_wait && dmem_en_wb && !ex_wb;
   assign kill_wb  = stall_wb || ex_wb;

   // only loads write a register, so that picks the fault kind
   assign exception_code_wb = had_ex_wb ? prev_ex_code_wb :
                              wr_reg_unkilled_wb ? ecode_load_access_fault :
                              ecode_store_access_fault;
   assign exception_wb = ex_wb;
   assign retire_wb    = !(prev_killed_wb || kill_wb);
   assign load_in_wb   = dmem_en_wb && !store_in_wb;

   assign wb       = '{wr_reg: wr_reg_unkilled_wb && !kill_wb, reg_to_wr: reg_to_wr_wb,
                       wb_src_sel: wb_src_sel_wb};
   assign dmem_req = '{en: dmem_en_dx, wen: dmem_wen_dx, size: dmem_size,
                       mem_type: dmem_type};
   assign status   = '{stall_if: stall_if, kill_if: kill_if, stall_dx: stall_dx,
                       kill_dx: kill_dx, stall_wb: stall_wb, kill_wb: kill_wb};

endmodule

/* core_ctrl.sv */
`timescale 1ns/1ps

module core_ctrl
   import rv32_isa_pkg::*;
   import pipe_ctrl_pkg::*;
(
   input  logic         clk,
   input  logic         reset,
   input  rv32_inst_u   inst_dx,
   input  logic         imem_wait,
   input  logic         imem_badmem_e,
   input  logic         dmem_wait,
   input  logic         dmem_badmem_e,
   input  logic         cmp_true,
   input  logic         misaligned_addr_p,
   input  logic         misaligned_fetch,
   output pc_src_sel_t  pc_src_sel,
   output alu_op_t      alu_op,
   output dx_ctrl_t     dx_ctrl,
   output logic         bypass_rs1,
   output logic         bypass_rs2,
   output dmem_req_t    dmem_req,
   output wb_ctrl_t     wb,
   output pipe_status_t status,
   output logic         exception_wb,
   output ecode_t       exception_code_wb,
   output logic         retire_wb
);

   decode_t    dec;
   logic [2:0] dmem_size;
   logic [2:0] dmem_type;
   logic       load_use;
   logic       load_in_wb;

   assign alu_op = dec.alu_op; // alu op is never killed

   inst_decoder inst_decoder_i (
      .inst_dx(inst_dx), .cmp_true(cmp_true), .dec(dec), .dx_ctrl(dx_ctrl),
      .dmem_size(dmem_size), .dmem_type(dmem_type)
   );

   hazard_unit hazard_unit_i (
      .inst_dx(inst_dx), .uses_rs1(dec.uses_rs1), .uses_rs2(dec.uses_rs2), .wb(wb),
      .load_in_wb(load_in_wb), .bypass_rs1(bypass_rs1), .bypass_rs2(bypass_rs2),
      .load_use(load_use)
   );

   pipe_ctrl pipe_ctrl_i (
      .clk(clk), .reset(reset), .dec(dec), .rd_dx(inst_dx.r_view.rd), .load_use(load_use),
      .imem_wait(imem_wait), .imem_badmem_e(imem_badmem_e), .dmem_wait(dmem_wait),
      .dmem_badmem_e(dmem_badmem_e), .misaligned_addr_p(misaligned_addr_p),
      .misaligned_fetch(misaligned_fetch), .dmem_size(dmem_size), .dmem_type(dmem_type),
      .pc_src_sel(pc_src_sel), .dmem_req(dmem_req), .wb(wb), .load_in_wb(load_in_wb),
      .status(status), .exception_wb(exception_wb), .exception_code_wb(exception_code_wb),
      .retire_wb(retire_wb)
   );

endmodule

/* tb_core_ctrl.sv */
`timescale 1ns/1ps

module tb_core_ctrl
   import rv32_isa_pkg::*;
   import pipe_ctrl_pkg::*;
;

   logic         clk;
   logic         reset;
   rv32_inst_u   inst_dx;
   logic         imem_wait, imem_badmem_e, dmem_wait, dmem_badmem_e;
   logic         cmp_true, misaligned_addr_p, misaligned_fetch;
   pc_src_sel_t  pc_src_sel;
   alu_op_t      alu_op;
   dx_ctrl_t     dx_ctrl;
   logic         bypass_rs1, bypass_rs2;
   dmem_req_t    dmem_req;
   wb_ctrl_t     wb;
   pipe_status_t status;
   logic         exception_wb, retire_wb;
   ecode_t       exception_code_wb;

   int tab [0:127][0:20]; // one row per cycle
   int n_lines;
   int cycles;
   int cycle_limit;
   int errors, test_errors, checks;
   int tests_run, tests_failed;

   core_ctrl core_ctrl_i (
      .clk(clk), .reset(reset), .inst_dx(inst_dx), .imem_wait(imem_wait),
      .imem_badmem_e(imem_badmem_e), .dmem_wait(dmem_wait), .dmem_badmem_e(dmem_badmem_e),
      .cmp_true(cmp_true), .misaligned_addr_p(misaligned_addr_p),
      .misaligned_fetch(misaligned_fetch), .pc_src_sel(pc_src_sel), .alu_op(alu_op),
      .dx_ctrl(dx_ctrl), .bypass_rs1(bypass_rs1), .bypass_rs2(bypass_rs2),
      .dmem_req(dmem_req), .wb(wb), .status(status), .exception_wb(exception_wb),
      .exception_code_wb(exception_code_wb), .retire_wb(retire_wb)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   always @(posedge clk) begin
      cycles++;
      if (cycles > cycle_limit) begin
         $display("timeout after %0d cycles, the run did not finish", cycles);
         $display("Some tests failed");
         $finish;
      end
   end

   // ff in an expected column means not checked
   task automatic compare(input string name, input int exp, input int act);
      if (exp != 'hff) begin
         checks++;
         assert (exp == act)
         else begin
            $display("error at %0t: %s expected %0h, got %0h", $time, name, exp, act);
            errors++;
            test_errors++;
         end
      end
   endtask

   // RV32I formats that carry a destination register
   function automatic logic writes_rd(input rv32_inst_u inst);
      case (inst.r_view.opcode)
         op_load, op_jal, op_jalr, op_op_imm, op_op, op_auipc, op_lui: return 1'b1;
         default: return 1'b0;
      endcase
   endfunction

   // a retiring instruction writes its rd, anything else writes nothing
   task automatic check_wb(input int exp_retire, input rv32_inst_u inst);
      if (exp_retire == 0) begin
         compare("wb.wr_reg", 0, int'(wb.wr_reg));
      end else if (exp_retire == 1) begin
         compare("wb.wr_reg", int'(writes_rd(inst)), int'(wb.wr_reg));
         compare("wb.reg_to_wr", int'(inst.r_view.rd), int'(wb.reg_to_wr));
         compare("wb.wb_src_sel", int'(inst.r_view.opcode == op_load), int'(wb.wb_src_sel));
      end
   endtask

   // redirect, replay and handler drop the fetched word
   task automatic check_kills(input int exp_pc, input int exp_stall_dx, input int exp_stall_wb,
                              input int exp_ex);
      if (exp_pc != 'hff && exp_pc != 0)
         compare("kill_if", 1, int'(status.kill_if));
      if (exp_stall_dx == 1)
         compare("kill_dx", 1, int'(status.kill_dx));
      if (exp_stall_wb == 1 || exp_ex == 1)
         compare("kill_wb", 1, int'(status.kill_wb));
   endtask

   task automatic close_test(input int num);
      tests_run++;
      if (test_errors != 0)
         tests_failed++;
      $display("test %0d %s, %0d errors", num, (test_errors == 0) ? "ok" : "FAILED",
               test_errors);
      test_errors = 0;
   endtask

   initial begin
      int         fd;
      int         n;
      int         cur_test;
      string      line;
      int         v [0:20];
      rv32_inst_u in_wb;

      reset = 1'b1;
      inst_dx = 32'h00000013;
      in_wb = 32'h00000013;
      {imem_wait, imem_badmem_e, dmem_wait, dmem_badmem_e} = 4'b0;
      {cmp_true, misaligned_addr_p, misaligned_fetch} = 3'b0;
      n_lines = 0;
      cur_test = -1;
      fd = $fopen("core_ctrl_testdata.txt", "r");
      if (fd == 0) begin
         $display("could not open core_ctrl_testdata.txt");
         $display("Some tests failed");
         $finish;
      end else begin
         while ($fgets(line, fd) > 0) begin
            if (line.len() > 1 && line[0] != "#") begin
               n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                  v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7], v[8], v[9], v[10],
                  v[11], v[12], v[13], v[14], v[15], v[16], v[17], v[18], v[19], v[20]);
               if (n == 21) begin
                  for (int c = 0; c < 21; c++)
                     tab[n_lines][c] = v[c];
                  n_lines++;
               end
            end
         end
         $fclose(fd);
         cycle_limit = n_lines + 5 + 20;

         repeat (5) @(posedge clk);
         for (int i = 0; i < n_lines; i++) begin
            #2;
            if (cur_test != -1 && tab[i][0] != cur_test)
               close_test(cur_test);
            cur_test = tab[i][0];
            if (i > 0 && tab[i-1][17] != 1)
               in_wb = tab[i-1][1]; // frozen WB keeps its word
            reset = 1'b0;
            inst_dx = tab[i][1];
            {imem_wait, imem_badmem_e, dmem_wait, dmem_badmem_e} =
               {tab[i][2][0], tab[i][3][0], tab[i][4][0], tab[i][5][0]};
            {cmp_true, misaligned_addr_p, misaligned_fetch} =
               {tab[i][6][0], tab[i][7][0], tab[i][8][0]};
            #36;
            compare("pc_src_sel", tab[i][9], int'(pc_src_sel));
            compare("alu_op", tab[i][10], int'(alu_op));
            compare("dx_ctrl", tab[i][11], int'(dx_ctrl));
            compare("bypass_rs1", tab[i][12], int'(bypass_rs1));
            compare("bypass_rs2", tab[i][13], int'(bypass_rs2));
            compare("dmem_req.en", tab[i][14], int'(dmem_req.en));
            compare("dmem_req.wen", (tab[i][14] == 1) ?
                    int'(inst_dx.r_view.opcode == op_store) : tab[i][14], int'(dmem_req.wen));
            compare("stall_dx", tab[i][15], int'(status.stall_dx));
            compare("stall_if", tab[i][16], int'(status.stall_if));
            compare("stall_wb", tab[i][17], int'(status.stall_wb));
            compare("exception_wb", tab[i][18], int'(exception_wb));
            compare("exception_code_wb", tab[i][19], int'(exception_code_wb));
            compare("retire_wb", tab[i][20], int'(retire_wb));
            check_kills(tab[i][9], tab[i][15], tab[i][17], tab[i][18]);
            check_wb(tab[i][20], in_wb);
            @(posedge clk);
         end
         if (cur_test != -1)
            close_test(cur_test);
         $display("%0d tests, %0d failed, %0d checks, %0d errors",
                  tests_run, tests_failed, checks, errors);
         if (errors == 0 && n_lines > 0)
            $display("All tests passed");
         else
            $display("Some tests failed");
         $finish;
      end
   end

endmodule

/* core_ctrl_testdata.txt */
# test inst iw ib dw db cmp ma mf | exp: pc alu dxc b1 b2 den sdx sif swb exc code ret
# all hex, ff = not checked; dxc = {imm_type, src_a, src_b}
1 00000013 0 0 0 0 0 0 0 4 ff ff ff ff 0 ff ff 0 0 ff 0
1 002082b3 0 0 0 0 0 0 0 0 0 00 ff ff ff ff ff ff ff ff ff
1 402082b3 0 0 0 0 0 0 0 0 a 00 ff ff ff ff ff ff ff ff ff
1 4020d2b3 0 0 0 0 0 0 0 0 b 00 ff ff ff ff ff ff ff ff ff
1 0020b2b3 0 0 0 0 0 0 0 0 e 00 ff ff ff ff ff ff ff ff ff
1 123452b7 0 0 0 0 0 0 0 0 0 29 ff ff ff ff ff ff ff ff ff
1 12345297 0 0 0 0 0 0 0 0 0 25 ff ff ff ff ff ff ff ff ff
1 00208063 0 0 0 0 0 0 0 0 8 00 ff ff ff ff ff ff ff ff ff
1 00209063 0 0 0 0 0 0 0 0 9 00 ff ff ff ff ff ff ff ff ff
1 0020c063 0 0 0 0 0 0 0 0 c 00 ff ff ff ff ff ff ff ff ff
1 0020d063 0 0 0 0 0 0 0 0 d 00 ff ff ff ff ff ff ff ff ff
1 0020e063 0 0 0 0 0 0 0 0 e 00 ff ff ff ff ff ff ff ff ff
1 0020f063 0 0 0 0 0 0 0 0 f 00 ff ff ff ff ff ff ff ff ff
2 00208063 0 0 0 0 1 0 0 1 8 00 ff ff ff ff ff ff ff ff ff
2 000000ef 0 0 0 0 0 0 0 2 0 06 ff ff ff ff ff ff ff ff ff
2 000100e7 0 0 0 0 0 0 0 3 0 06 ff ff ff ff ff ff ff ff ff
2 00208063 1 0 0 0 1 0 0 1 ff ff ff ff ff ff ff ff ff ff ff
2 00000013 0 0 0 0 0 0 0 4 ff ff ff ff ff ff ff ff ff ff ff
3 002082b3 0 0 0 0 0 0 0 ff ff ff 0 0 ff 0 ff ff ff ff ff
3 00128313 0 0 0 0 0 0 0 ff ff ff 1 0 ff 0 ff ff ff ff ff
3 0000a283 0 0 0 0 0 0 0 ff ff ff ff ff 1 0 ff ff ff ff ff
3 005083b3 0 0 0 0 0 0 0 4 ff ff 0 0 ff 1 1 ff ff ff ff
3 005083b3 0 0 0 0 0 0 0 0 ff ff ff 0 ff 0 ff ff ff ff ff
3 00208033 0 0 0 0 0 0 0 ff ff ff ff ff ff 0 ff ff ff ff ff
3 00100313 0 0 0 0 0 0 0 ff ff ff 0 0 ff 0 ff ff ff ff ff
4 0000a283 0 0 0 0 0 0 0 ff ff ff ff ff 1 0 ff ff ff ff ff
4 00000013 0 0 1 0 0 0 0 4 ff ff ff ff ff 1 1 1 ff ff 0
4 00000013 0 0 1 0 0 0 0 4 ff ff ff ff ff 1 1 1 ff ff 0
4 00000013 0 0 1 0 0 0 0 4 ff ff ff ff ff 1 1 1 ff ff 0
4 00000013 0 0 0 0 0 0 0 0 ff ff ff ff ff 0 0 0 ff ff 1
5 00000000 0 0 0 0 0 0 0 0 ff ff ff ff 0 ff ff ff 0 ff ff
5 00000013 0 0 0 0 0 0 0 5 ff ff ff ff ff ff ff ff 1 2 ff
5 00000073 0 0 0 0 0 0 0 ff ff ff ff ff 0 ff ff ff 0 ff ff
5 00000013 0 0 0 0 0 0 0 5 ff ff ff ff ff ff ff ff 1 b ff
5 00100073 0 0 0 0 0 0 0 ff ff ff ff ff 0 ff ff ff 0 ff ff
5 00000013 0 0 0 0 0 0 0 5 ff ff ff ff ff ff ff ff 1 3 ff
5 0020a023 0 0 0 0 0 1 0 ff ff ff ff ff 0 ff ff ff 0 ff ff
5 00000013 0 0 0 0 0 0 0 5 ff ff ff ff ff ff ff ff 1 6 ff
5 00000013 0 1 0 0 0 0 0 ff ff ff ff ff ff ff ff ff 0 ff ff
5 0000a283 0 0 0 0 0 0 0 ff ff ff ff ff 0 ff ff ff 0 ff ff
5 00000013 0 0 0 0 0 0 0 5 ff ff ff ff ff ff ff ff 1 1 ff
5 0000a283 0 0 0 0 0 0 0 ff ff ff ff ff 1 ff ff ff 0 ff ff
5 00000013 0 0 0 1 0 0 0 5 ff ff ff ff ff ff ff ff 1 5 ff
6 0020a023 0 0 0 0 0 0 0 ff ff ff ff ff 1 0 ff ff ff ff ff
6 0000100f 0 0 0 0 0 0 0 4 ff ff ff ff ff 1 1 ff ff ff ff
6 0000100f 0 0 0 0 0 0 0 4 ff ff ff ff ff 0 0 ff ff ff ff
6 00000013 0 0 0 0 0 0 0 0 ff ff ff ff ff 0 ff ff ff ff ff

/* all.f */
rv32_isa_pkg.sv
pipe_ctrl_pkg.sv
inst_decoder.sv
hazard_unit.sv
pipe_ctrl.sv
core_ctrl.sv
tb_core_ctrl.sv

/* run.sh */
#!/bin/sh
rm -f sim.log
verilator --binary -f all.f --top-module tb_core_ctrl -o sim_core_ctrl || exit 1
./obj_dir/sim_core_ctrl | tee sim.log || exit 1
test -s sim.log || exit 1
grep -q "Some tests failed" sim.log && exit 1
grep -q "All tests passed" sim.log || exit 1
exit 0
